// File: invaders_core.f
verilog/invaders_pkg.sv
verilog/video_timing.sv
verilog/pixel_fetch.sv
verilog/barrel_shifter.sv
verilog/io_ports.sv
verilog/sound_latch.sv
verilog/invaders_core.sv
verif/tb_invaders_core.sv

// File: run_sim.sh
#!/bin/bash
# build and run the invaders_core testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert \
	--top-module tb_invaders_core \
	-f invaders_core.f \
	-Mdir obj_dir
./obj_dir/Vtb_invaders_core | tee sim.log
if grep -q "Some tests failed" sim.log
then
	exit 1
fi

// File: verif/tb_invaders_core.sv
// testbench for invaders_core with video ram model, directed tests, checker and watchdog
`timescale 1ns/10ps

module tb_invaders_core
	import invaders_pkg::*;
();

	localparam int LINE_CLKS    = 320;
	localparam int HBLANK_CLKS  = 64;
	localparam int HSYNC_CLKS   = 16;
	localparam int FRAME_LINES  = 262;
	localparam int VBLANK_LINES = 38;
	localparam int VSYNC_LINES  = 4;
	localparam int TEST_LINES   = 4;
	localparam int FRAME_NS     = 10 * LINE_CLKS * FRAME_LINES;
	// the run lasts about three frames and six give margin
	localparam int WATCHDOG_NS  = 6 * FRAME_NS;

	logic               clk = 1'b0;
	logic               arst_n;
	logic               flip;
	cpu_io_t            cpu;
	player_t            player;
	dip_t               dip;
	logic [7:0]         rdata;
	logic [VRAM_AW-1:0] vram_addr;
	logic [7:0]         vram_data = 8'h00;
	logic               video;
	sync_t              sync_out;
	logic               csync_n;
	logic [5:0]         sound_a;
	logic [4:0]         sound_b;
	logic               sound_ser;
	logic               sound_load;

	logic [7:0] vram [2**VRAM_AW];
	integer     seed = 32'h678643cb;
	int         errors = 0;
	int         checks = 0;
	int         tests = 0;

	always #5 clk = ~clk;

	invaders_core u_dut (.*);

	// synchronous ram returns the byte one edge after the address
	always @(posedge clk)
		vram_data <= vram[vram_addr];

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		$display("test %s finished with %0d errors", name, errors - errors_before);
	endtask

	// one clock write strobe
	task automatic write_port(input io_port_e port, input logic [7:0] data);
		@(posedge clk);
		cpu <= '{wr: 1'b1, port: port, wdata: data};
		@(posedge clk);
		cpu.wr <= 1'b0;
	endtask

	// read data is combinational and sampled mid cycle
	task automatic read_port(input io_port_e port, output logic [7:0] data);
		@(posedge clk);
		cpu <= '{wr: 1'b0, port: port, wdata: 8'h00};
		@(negedge clk);
		data = rdata;
	endtask

	// entered on pixel 0 and left on pixel 0 of the next line
	task automatic capture_line(input int line);
		logic [7:0] vcount;
		logic [7:0] row;
		logic [4:0] col;
		logic [2:0] bit_idx;
		logic [7:0] byte_val;
		vcount = 8'h20 + 8'(line);
		for (int p = 0; p < 256; p++)
		begin
			// flipped screen mirrors rows and columns and sends msb first
			if (flip)
			begin
				row = ~vcount + 8'h20;
				col = ~5'(p / 8);
				bit_idx = 3'd7 - 3'(p % 8);
			end
			else
			begin
				row = vcount;
				col = 5'(p / 8);
				bit_idx = 3'(p % 8);
			end
			byte_val = vram[{row, col}];
			check("video", 32'(video), 32'(byte_val[bit_idx]));
			@(negedge clk);
		end
		check("sync_out.hblank", 32'(sync_out.hblank), 32'h1);
		while (sync_out.hblank)
		begin
			check("video in hblank", 32'(video), 32'h0);
			@(negedge clk);
		end
	endtask

	task automatic measure_timing();
		int   err0;
		int   lines;
		int   line_clks;
		int   hblank_clks;
		int   hsync_clks;
		int   frame_clks;
		int   vblank_clks;
		int   vsync_clks;
		int   csync_clks;
		logic prev_hblank;
		logic prev_vblank;
		err0 = errors;
		@(negedge clk);
		check("sync_out", 32'(sync_out), 32'h0);
		check("video", 32'(video), 32'h0);
		check("csync_n", 32'(csync_n), 32'h1);
		do @(negedge clk); while (!sync_out.vblank);
		lines = 0;
		line_clks = 0;
		hblank_clks = 0;
		hsync_clks = 0;
		frame_clks = 0;
		vblank_clks = 0;
		vsync_clks = 0;
		csync_clks = 0;
		// vblank starts inside hblank so the first partial line is not measured
		prev_hblank = 1'b1;
		do
		begin
			if (sync_out.hblank && !prev_hblank)
			begin
				if (lines > 0)
				begin
					check("line length", 32'(line_clks), 32'(LINE_CLKS));
					check("hblank length", 32'(hblank_clks), 32'(HBLANK_CLKS));
					check("hsync length", 32'(hsync_clks), 32'(HSYNC_CLKS));
				end
				lines++;
				line_clks = 0;
				hblank_clks = 0;
				hsync_clks = 0;
			end
			line_clks++;
			frame_clks++;
			if (sync_out.hblank)
				hblank_clks++;
			if (sync_out.hsync)
				hsync_clks++;
			if (sync_out.vblank)
				vblank_clks++;
			if (sync_out.vsync)
				vsync_clks++;
			if (!csync_n)
				csync_clks++;
			check("sync_out.hsync outside hblank", 32'(sync_out.hsync && !sync_out.hblank), 0);
			check("sync_out.vsync outside vblank", 32'(sync_out.vsync && !sync_out.vblank), 0);
			prev_hblank = sync_out.hblank;
			prev_vblank = sync_out.vblank;
			@(negedge clk);
		end
		while (!(sync_out.vblank && !prev_vblank));
		check("lines per frame", 32'(lines), 32'(FRAME_LINES));
		check("frame length", 32'(frame_clks), 32'(FRAME_LINES * LINE_CLKS));
		check("vblank length", 32'(vblank_clks), 32'(VBLANK_LINES * LINE_CLKS));
		check("vsync length", 32'(vsync_clks), 32'(VSYNC_LINES * LINE_CLKS));
		// hsync pulses of the vsync lines fall inside vsync
		check("csync_n low clocks", 32'(csync_clks),
			32'(VSYNC_LINES * LINE_CLKS + (FRAME_LINES - VSYNC_LINES) * HSYNC_CLKS));
		finish_test("line and frame timing", err0);
	endtask

	task automatic compare_bitmap(input logic flipped, input string name);
		int err0;
		err0 = errors;
		@(posedge clk);
		flip <= flipped;
		// top of the next frame
		do @(negedge clk); while (!sync_out.vblank);
		while (sync_out.vblank || sync_out.hblank)
		begin
			check("video in blank", 32'(video), 32'h0);
			@(negedge clk);
		end
		for (int l = 0; l < TEST_LINES; l++)
			capture_line(l);
		finish_test(name, err0);
	endtask

	task automatic exercise_shifter();
		int          err0;
		logic [31:0] rnd;
		logic [15:0] shifted;
		logic [7:0]  got;
		err0 = errors;
		for (int n = 0; n < 8; n++)
		begin
			rnd = $random(seed);
			write_port(PORT_SHIFT_DATA, rnd[7:0]);
			write_port(PORT_SHIFT_DATA, rnd[15:8]);
			// upper bits of the amount are ignored
			write_port(PORT_SHIFT_AMT, {rnd[23:19], 3'(n)});
			shifted = rnd[15:0] >> (8 - n);
			read_port(PORT_SHIFT_RES, got);
			check("rdata port 3", 32'(got), 32'(shifted[7:0]));
		end
		finish_test("barrel shifter", err0);
	endtask

	task automatic sample_inputs();
		int          err0;
		logic [31:0] rnd;
		logic [7:0]  got;
		player_t     pl;
		dip_t        dp;
		err0 = errors;
		repeat (6)
		begin
			rnd = $random(seed);
			pl = rnd[6:0];
			dp = rnd[10:7];
			@(posedge clk);
			player <= pl;
			dip <= dp;
			read_port(PORT_IN1, got);
			check("rdata port 1", 32'(got), 32'({1'b0, pl.right, pl.left, pl.fire,
				1'b1, pl.start2, pl.start1, pl.coin}));
			read_port(PORT_IN2, got);
			check("rdata port 2", 32'(got), 32'({dp.dip7, pl.right, pl.left, pl.fire,
				dp.dip6, pl.tilt, dp.dip5, dp.dip3}));
			read_port(io_port_e'(3'd6), got);
			check("rdata port 6", 32'(got), 32'h0);
		end
		finish_test("input ports", err0);
	endtask

	task automatic collect_sound();
		int          err0;
		logic [31:0] rnd;
		logic [15:0] frame_exp;
		logic [15:0] frame_got;
		err0 = errors;
		repeat (3)
		begin
			rnd = $random(seed);
			write_port(PORT_SOUND1, rnd[7:0]);
			write_port(PORT_SOUND2, rnd[15:8]);
			@(negedge clk);
			check("sound_a", 32'(sound_a), 32'(rnd[5:0]));
			check("sound_b", 32'(sound_b), 32'(rnd[12:8]));
			frame_exp = {6'b000000, rnd[12:8], 1'b0, rnd[3:1], ~rnd[0]};
			// bit 15 goes out with the load strobe
			while (!sound_load)
				@(negedge clk);
			for (int i = 15; i >= 0; i--)
			begin
				frame_got[i] = sound_ser;
				@(negedge clk);
			end
			check("sound_ser frame", 32'(frame_got), 32'(frame_exp));
		end
		finish_test("sound", err0);
	endtask

	initial
	begin
		arst_n = 1'b0;
		flip = 1'b0;
		cpu = '{wr: 1'b0, port: PORT_IN1, wdata: 8'h00};
		player = '0;
		dip = '0;
		for (int i = 0; i < 2**VRAM_AW; i++)
			vram[i] = 8'($random(seed));
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		measure_timing();
		compare_bitmap(1'b0, "unflipped bitmap");
		compare_bitmap(1'b1, "flipped bitmap");
		exercise_shifter();
		sample_inputs();
		collect_sound();
		$display("tests run %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// hang guard
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: verilog/barrel_shifter.sv
// 16 bit shift register with 3 bit offset, 8 bit window read back
`timescale 1ns/10ps

module barrel_shifter (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       data_wr,
	input  logic       amount_wr,
	input  logic [7:0] wdata,
	output logic [7:0] result
);

	logic [15:0] shift_reg;
	logic [2:0]  amount;
	logic [15:0] shifted;

	// new byte in on top, old top drops to the low half
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			shift_reg <= '0;
		else if (data_wr)
			shift_reg <= {wdata, shift_reg[15:8]};
	end

	// offset, only low three bits matter
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			amount <= '0;
		else if (amount_wr)
			amount <= wdata[2:0];
	end

	// >> (8 - n) keeping 8 bits is the same as << n keeping the upper byte
	assign shifted = shift_reg << amount;
	assign result  = shifted[15:8];

endmodule

// File: verilog/invaders_core.sv
// top level joining video timing, pixel fetch, i/o ports and sound
`timescale 1ns/10ps

module invaders_core
	import invaders_pkg::*;
(
	input  logic               clk,
	input  logic               arst_n,
	input  logic               flip,
	input  cpu_io_t            cpu,
	input  player_t            player,
	input  dip_t               dip,
	output logic [7:0]         rdata,
	output logic [VRAM_AW-1:0] vram_addr,
	input  logic [7:0]         vram_data,
	output logic               video,
	output sync_t              sync_out,
	output logic               csync_n,
	output logic [5:0]         sound_a,
	output logic [4:0]         sound_b,
	output logic               sound_ser,
	output logic               sound_load
);

	scan_pos_t pos;
	sync_t     sync;

	video_timing u_timing (
		.clk    (clk),
		.arst_n (arst_n),
		.pos    (pos),
		.sync   (sync)
	);

	pixel_fetch u_fetch (
		.clk       (clk),
		.arst_n    (arst_n),
		.pos       (pos),
		.sync      (sync),
		.flip      (flip),
		.vram_addr (vram_addr),
		.vram_data (vram_data),
		.video     (video),
		.sync_out  (sync_out)
	);

	io_ports u_io (
		.clk    (clk),
		.arst_n (arst_n),
		.cpu    (cpu),
		.player (player),
		.dip    (dip),
		.rdata  (rdata)
	);

	sound_latch u_sound (
		.clk        (clk),
		.arst_n     (arst_n),
		.cpu        (cpu),
		.sound_a    (sound_a),
		.sound_b    (sound_b),
		.sound_ser  (sound_ser),
		.sound_load (sound_load)
	);

	// composite sync from the pixel aligned syncs
	assign csync_n = ~(sync_out.hsync | sync_out.vsync);

endmodule

// File: verilog/invaders_pkg.sv
// timing constants, i/o port numbers and bus structs for the invaders video and i/o core
package invaders_pkg;

	// horizontal count: 000..0ff active, then 1c0..1ff blank, 320 clocks per line
	localparam logic [8:0] H_ACTIVE_LAST  = 9'h0ff;
	localparam logic [8:0] H_BLANK_FIRST  = 9'h1c0;

	// vertical count: 020..0ff active, 1da..1ff blank, 262 lines per frame
	localparam logic [8:0] V_ACTIVE_FIRST = 9'h020;
	localparam logic [8:0] V_ACTIVE_LAST  = 9'h0ff;
	localparam logic [8:0] V_BLANK_FIRST  = 9'h1da;
	localparam logic [8:0] V_BLANK_LAST   = 9'h1ff;

	// 8 KB video ram, one byte = 8 pixels
	localparam int VRAM_AW     = 13;
	// scan position to visible pixel latency
	localparam int PIX_PIPE    = 3;
	// serial sound frame length
	localparam int SOUND_FRAME = 16;

	// raw scan counters
	typedef struct packed {
		logic [8:0] hcount;
		logic [8:0] vcount;
	} scan_pos_t;

	// blanking and sync decode
	typedef struct packed {
		logic hblank;
		logic vblank;
		logic hsync;
		logic vsync;
	} sync_t;

	// port numbers as seen by cpu writes
	typedef enum logic [2:0] {
		PORT_IN1        = 3'd1,
		PORT_SHIFT_AMT  = 3'd2,
		PORT_SOUND1     = 3'd3,
		PORT_SHIFT_DATA = 3'd4,
		PORT_SOUND2     = 3'd5
	} io_port_e;

	// read side reuses the write numbers
	localparam io_port_e PORT_IN2       = PORT_SHIFT_AMT;
	localparam io_port_e PORT_SHIFT_RES = PORT_SOUND1;

	// cpu port bus, wr is a one clock strobe
	typedef struct packed {
		logic       wr;
		io_port_e   port;
		logic [7:0] wdata;
	} cpu_io_t;

	// player controls, active high
	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic fire;
		logic left;
		logic right;
		logic tilt;
	} player_t;

	// dip switches, lives and bonus
	typedef struct packed {
		logic dip3;
		logic dip5;
		logic dip6;
		logic dip7;
	} dip_t;

endpackage

// File: verilog/io_ports.sv
// port write decode for the shifter and the cpu read multiplexer
`timescale 1ns/10ps

module io_ports
	import invaders_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  cpu_io_t    cpu,
	input  player_t    player,
	input  dip_t       dip,
	output logic [7:0] rdata
);

	logic       data_wr;
	logic       amount_wr;
	logic [7:0] shift_result;

	// shifter writes, both take effect at the strobe edge
	assign data_wr   = cpu.wr && (cpu.port == PORT_SHIFT_DATA);
	assign amount_wr = cpu.wr && (cpu.port == PORT_SHIFT_AMT);

	barrel_shifter u_shifter (
		.clk       (clk),
		.arst_n    (arst_n),
		.data_wr   (data_wr),
		.amount_wr (amount_wr),
		.wdata     (cpu.wdata),
		.result    (shift_result)
	);

	// read mux, combinational on the port number
	always_comb
	begin
		case (cpu.port)
			PORT_IN1:
				// bit 3 tied high on the board
				rdata = {1'b0, player.right, player.left, player.fire,
					1'b1, player.start2, player.start1, player.coin};
			PORT_IN2:
				rdata = {dip.dip7, player.right, player.left, player.fire,
					dip.dip6, player.tilt, dip.dip5, dip.dip3};
			PORT_SHIFT_RES:
				rdata = shift_result;
			default:
				rdata = 8'h00;
		endcase
	end

	// writes only go to ports decoded here or in the sound latches
	wr_port_known_a: assert property (@(posedge clk) disable iff (!arst_n)
		cpu.wr |-> cpu.port inside {PORT_SHIFT_AMT, PORT_SOUND1, PORT_SHIFT_DATA,
			PORT_SOUND2});

endmodule

// File: verilog/pixel_fetch.sv
// video ram addressing with flip, byte load, pixel serializer and aligned sync delay
`timescale 1ns/10ps

module pixel_fetch
	import invaders_pkg::*;
(
	input  logic               clk,
	input  logic               arst_n,
	input  scan_pos_t          pos,
	input  sync_t              sync,
	input  logic               flip,
	output logic [VRAM_AW-1:0] vram_addr,
	input  logic [7:0]         vram_data,
	output logic               video,
	output sync_t              sync_out
);

	logic [7:0] row;
	logic [4:0] col;
	logic       load;
	logic [7:0] pix;
	sync_t      sync_pipe [PIX_PIPE];

	// flipped screen mirrors both axes, row offset keeps line 020 on ff
	always_comb
	begin
		if (flip)
		begin
			row = ~pos.vcount[7:0] + 8'h20;
			col = ~pos.hcount[7:3];
		end
		else
		begin
			row = pos.vcount[7:0];
			col = pos.hcount[7:3];
		end
	end

	// address out one clock after pos, ram answers one clock later
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			vram_addr <= '0;
		else
			vram_addr <= {row, col};
	end

	// byte lands two clocks into the column, first pixel then shows at pos + PIX_PIPE
	assign load = (pos.hcount[2:0] == 3'(PIX_PIPE - 1));

	// shift right unflipped, left when flipped
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pix <= '0;
		else if (load)
			pix <= vram_data;
		else if (flip)
			pix <= {pix[6:0], 1'b0};
		else
			pix <= {1'b0, pix[7:1]};
	end

	// sync delayed to line up with the pixel stream
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < PIX_PIPE; i++)
				sync_pipe[i] <= '0;
		end
		else
		begin
			sync_pipe[0] <= sync;
			for (int i = 1; i < PIX_PIPE; i++)
				sync_pipe[i] <= sync_pipe[i-1];
		end
	end

	assign sync_out = sync_pipe[PIX_PIPE-1];

	// blanked with the aligned blanks
	assign video = (flip ? pix[7] : pix[0]) & ~(sync_out.hblank | sync_out.vblank);

	// in active video a new byte comes only after all 8 pixels of the last one
	load_on_byte_a: assert property (@(posedge clk) disable iff (!arst_n)
		load && !(sync_out.hblank || sync_out.vblank) |=> !load [*7] ##1 load);

endmodule

// File: verilog/sound_latch.sv
// two sound latches and the serial sound frame with its load strobe
`timescale 1ns/10ps

module sound_latch
	import invaders_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  cpu_io_t    cpu,
	output logic [5:0] sound_a,
	output logic [4:0] sound_b,
	output logic       sound_ser,
	output logic       sound_load
);

	localparam int CW = $clog2(SOUND_FRAME);

	logic [CW-1:0]          bit_cnt;
	logic [SOUND_FRAME-1:0] frame;

	// latches, port 3 and port 5
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sound_a <= '0;
			sound_b <= '0;
		end
		else if (cpu.wr)
		begin
			if (cpu.port == PORT_SOUND1)
				sound_a <= cpu.wdata[5:0];
			if (cpu.port == PORT_SOUND2)
				sound_b <= cpu.wdata[4:0];
		end
	end

	// free running bit counter
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			bit_cnt <= '0;
		else
			bit_cnt <= bit_cnt + 1'b1;
	end

	// board order, a4 and a5 not sent, a0 goes out inverted
	assign frame = {6'b000000, sound_b, 1'b0, sound_a[3:1], ~sound_a[0]};

	// msb first
	assign sound_ser  = frame[~bit_cnt];
	assign sound_load = (bit_cnt == '0);

	// one load per frame
	load_period_a: assert property (@(posedge clk) disable iff (!arst_n)
		sound_load |=> !sound_load [*SOUND_FRAME-1] ##1 sound_load);

endmodule

// File: verilog/video_timing.sv
// horizontal and vertical scan counters with blank and sync decode
`timescale 1ns/10ps

module video_timing
	import invaders_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	output scan_pos_t pos,
	output sync_t     sync
);

	logic [8:0] hcount;
	logic [8:0] vcount;

	// horizontal jumps the gap after active video and 1ff wraps to 0 by itself
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			hcount <= '0;
		else if (hcount == H_ACTIVE_LAST)
			hcount <= H_BLANK_FIRST;
		else
			hcount <= hcount + 9'd1;
	end

	// vertical steps once per line at the start of horizontal blank
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			vcount <= V_ACTIVE_FIRST;
		else if (hcount == H_BLANK_FIRST)
		begin
			if (vcount == V_ACTIVE_LAST)
				vcount <= V_BLANK_FIRST;
			else if (vcount == V_BLANK_LAST)
				vcount <= V_ACTIVE_FIRST;
			else
				vcount <= vcount + 9'd1;
		end
	end

	assign pos.hcount = hcount;
	assign pos.vcount = vcount;

	// blank and sync straight from counter bits
	assign sync.hblank = hcount[8];
	assign sync.hsync  = hcount[8] & hcount[4] & ~hcount[5];
	assign sync.vblank = vcount[8];
	assign sync.vsync  = vcount[8] & vcount[3] & vcount[2] & ~vcount[4];

	// vcount stays inside active or blank range
	vcount_range_a: assert property (@(posedge clk) disable iff (!arst_n)
		vcount inside {[V_ACTIVE_FIRST:V_ACTIVE_LAST], [V_BLANK_FIRST:V_BLANK_LAST]});

	// hsync only inside horizontal blank from 1c0 on
	hsync_in_blank_a: assert property (@(posedge clk) disable iff (!arst_n)
		sync.hsync |-> hcount >= H_BLANK_FIRST);

endmodule
